// ==== design/udp_ip_consts.svh ====
// Shared widths, header sizes and protocol numbers for the UDP/IP dispatch layer
`ifndef UDP_IP_CONSTS_SVH
`define UDP_IP_CONSTS_SVH

// Payload stream
`define UDP_IP_DATA_W 64
`define UDP_IP_KEEP_W 8

// Header sizes in bytes
`define UDP_HDR_BYTES 8
`define IP_HDR_BYTES  20

// IPv4 protocol field values
`define IP_PROTO_TCP 8'd6
`define IP_PROTO_UDP 8'd17

`endif

// ==== design/udp_ip_pkg.sv ====
// Types shared by the UDP/IP dispatch modules: header structs, beat struct and FSM enums
`include "udp_ip_consts.svh"

package udp_ip_pkg;

    typedef enum logic [7:0] {
        PROTO_TCP = `IP_PROTO_TCP,
        PROTO_UDP = `IP_PROTO_UDP
    } ip_proto_t;

    // Fields kept from the IPv4 header
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    typedef struct packed {
        ip_hdr_t  ip;
        udp_hdr_t udp;
    } udp_frame_hdr_t;

    // One payload beat, byte 0 in data[7:0]
    typedef struct packed {
        logic [`UDP_IP_DATA_W-1:0] data;
        logic [`UDP_IP_KEEP_W-1:0] keep;
        logic                      last;
        logic                      user;
    } axis_beat_t;

    typedef enum logic [1:0] {
        RX_HEADER,
        RX_PAYLOAD,
        RX_DROP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_IP_HDR,
        TX_UDP_HDR,
        TX_PAYLOAD
    } tx_state_t;

endpackage

// ==== design/proto_classifier.sv ====
// Receive classifier, steers each IP frame to the UDP parser or the raw IP output by protocol
`timescale 1ns/1ps

module proto_classifier (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_hdr_valid,
    output logic                   in_hdr_ready,
    input  udp_ip_pkg::ip_hdr_t    in_hdr,
    input  logic                   in_beat_valid,
    output logic                   in_beat_ready,
    input  udp_ip_pkg::axis_beat_t in_beat,
    output logic                   udp_hdr_valid,
    input  logic                   udp_hdr_ready,
    output logic                   udp_beat_valid,
    input  logic                   udp_beat_ready,
    output logic                   ip_hdr_valid,
    input  logic                   ip_hdr_ready,
    output logic                   ip_beat_valid,
    input  logic                   ip_beat_ready
);
    import udp_ip_pkg::*;

    logic busy;
    logic route_udp;
    logic hdr_is_udp;
    logic hdr_fire;
    logic last_fire;

    assign hdr_is_udp = (in_hdr.protocol == PROTO_UDP);

    // New headers wait until the previous frame has ended
    assign udp_hdr_valid = in_hdr_valid && !busy && hdr_is_udp;
    assign ip_hdr_valid  = in_hdr_valid && !busy && !hdr_is_udp;
    assign in_hdr_ready  = hdr_is_udp ? (udp_hdr_valid && udp_hdr_ready)
                                      : (ip_hdr_valid && ip_hdr_ready);
    assign hdr_fire = in_hdr_valid && in_hdr_ready;

    // Payload follows the route latched with the header
    assign udp_beat_valid = busy && route_udp && in_beat_valid;
    assign ip_beat_valid  = busy && !route_udp && in_beat_valid;
    assign in_beat_ready  = busy && (route_udp ? udp_beat_ready : ip_beat_ready);
    assign last_fire = in_beat_valid && in_beat_ready && in_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            route_udp <= 1'b0;
        end else if (hdr_fire) begin
            busy      <= 1'b1;
            route_udp <= hdr_is_udp;
        end else if (last_fire) begin
            busy <= 1'b0;
        end
    end

endmodule

// ==== design/udp_rx_parse.sv ====
// UDP receive parser, strips the UDP header beat and presents its fields beside the payload
`timescale 1ns/1ps

module udp_rx_parse (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_hdr_valid,
    output logic                       in_hdr_ready,
    input  udp_ip_pkg::ip_hdr_t        in_hdr,
    input  logic                       in_beat_valid,
    output logic                       in_beat_ready,
    input  udp_ip_pkg::axis_beat_t     in_beat,
    output logic                       out_hdr_valid,
    input  logic                       out_hdr_ready,
    output udp_ip_pkg::udp_frame_hdr_t out_hdr,
    output logic                       out_beat_valid,
    input  logic                       out_beat_ready,
    output udp_ip_pkg::axis_beat_t     out_beat,
    output logic                       error_header_early_termination
);
    import udp_ip_pkg::*;

    rx_state_t      state;
    logic           ip_held;
    logic           hdr_pending;
    logic           hdr_fire;
    logic           beat_fire;
    udp_frame_hdr_t hdr_reg;
    udp_hdr_t       beat_udp;

    // IP header taken at once, then the UDP header beat
    assign in_hdr_ready = in_hdr_valid && (state == RX_HEADER) && !ip_held;
    assign hdr_fire = in_hdr_valid && in_hdr_ready;

    assign in_beat_ready = (state == RX_HEADER) ? ip_held
                         : (state == RX_PAYLOAD) && !hdr_pending && out_beat_ready;
    assign beat_fire = in_beat_valid && in_beat_ready;

    // Big-endian fields, byte 0 first on the wire
    assign beat_udp.source_port = {in_beat.data[7:0], in_beat.data[15:8]};
    assign beat_udp.dest_port   = {in_beat.data[23:16], in_beat.data[31:24]};
    assign beat_udp.length      = {in_beat.data[39:32], in_beat.data[47:40]};
    assign beat_udp.checksum    = {in_beat.data[55:48], in_beat.data[63:56]};

    assign out_hdr_valid  = hdr_pending;
    assign out_hdr        = hdr_reg;
    assign out_beat_valid = (state == RX_PAYLOAD) && !hdr_pending && in_beat_valid;
    assign out_beat       = in_beat;

    assign error_header_early_termination = (state == RX_DROP);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= RX_HEADER;
            ip_held     <= 1'b0;
            hdr_pending <= 1'b0;
        end else begin
            case (state)
                RX_HEADER: begin
                    if (hdr_fire) begin
                        ip_held <= 1'b1;
                    end
                    if (beat_fire) begin
                        ip_held <= 1'b0;
                        if (in_beat.last) begin
                            state <= RX_DROP;
                        end else begin
                            state       <= RX_PAYLOAD;
                            hdr_pending <= 1'b1;
                        end
                    end
                end
                RX_PAYLOAD: begin
                    if (hdr_pending && out_hdr_ready) begin
                        hdr_pending <= 1'b0;
                    end
                    if (beat_fire && in_beat.last) begin
                        state <= RX_HEADER;
                    end
                end
                // Frame ended inside the header beat
                default: state <= RX_HEADER;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            hdr_reg.ip <= in_hdr;
        end
        if (beat_fire && (state == RX_HEADER)) begin
            hdr_reg.udp <= beat_udp;
        end
    end

endmodule

// ==== design/udp_tx_frame.sv ====
// UDP transmit framer, turns a UDP request into an IP frame led by the UDP header beat
`timescale 1ns/1ps
`include "udp_ip_consts.svh"

module udp_tx_frame (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_hdr_valid,
    output logic                       in_hdr_ready,
    input  udp_ip_pkg::udp_frame_hdr_t in_hdr,
    input  logic                       in_beat_valid,
    output logic                       in_beat_ready,
    input  udp_ip_pkg::axis_beat_t     in_beat,
    output logic                       out_hdr_valid,
    input  logic                       out_hdr_ready,
    output udp_ip_pkg::ip_hdr_t        out_hdr,
    output logic                       out_beat_valid,
    input  logic                       out_beat_ready,
    output udp_ip_pkg::axis_beat_t     out_beat
);
    import udp_ip_pkg::*;

    tx_state_t      state;
    udp_frame_hdr_t req;
    axis_beat_t     hdr_beat;

    assign in_hdr_ready = in_hdr_valid && (state == TX_IDLE);

    // IP length covers the UDP datagram plus the IP header
    always_comb begin
        out_hdr          = req.ip;
        out_hdr.length   = req.udp.length + 16'(`IP_HDR_BYTES);
        out_hdr.protocol = PROTO_UDP;
    end
    assign out_hdr_valid = (state == TX_IP_HDR);

    // High byte of source port lands in byte 0
    assign hdr_beat.data = {req.udp.checksum[7:0], req.udp.checksum[15:8],
                            req.udp.length[7:0], req.udp.length[15:8],
                            req.udp.dest_port[7:0], req.udp.dest_port[15:8],
                            req.udp.source_port[7:0], req.udp.source_port[15:8]};
    assign hdr_beat.keep = {`UDP_HDR_BYTES{1'b1}};
    assign hdr_beat.last = 1'b0;
    assign hdr_beat.user = 1'b0;

    assign out_beat_valid = (state == TX_UDP_HDR) || ((state == TX_PAYLOAD) && in_beat_valid);
    assign out_beat       = (state == TX_UDP_HDR) ? hdr_beat : in_beat;
    assign in_beat_ready  = (state == TX_PAYLOAD) && out_beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (in_hdr_valid) begin
                        state <= TX_IP_HDR;
                    end
                end
                TX_IP_HDR: begin
                    if (out_hdr_ready) begin
                        state <= TX_UDP_HDR;
                    end
                end
                TX_UDP_HDR: begin
                    if (out_beat_ready) begin
                        state <= TX_PAYLOAD;
                    end
                end
                default: begin
                    if (in_beat_valid && out_beat_ready && in_beat.last) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_hdr_valid && in_hdr_ready) begin
            req <= in_hdr;
        end
    end

endmodule

// ==== design/tx_arbiter.sv ====
// Transmit arbiter, fixed priority with input 0 first, locked to one frame at a time
`timescale 1ns/1ps

module tx_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_hdr_valid [2],
    output logic                   in_hdr_ready [2],
    input  udp_ip_pkg::ip_hdr_t    in_hdr [2],
    input  logic                   in_beat_valid [2],
    output logic                   in_beat_ready [2],
    input  udp_ip_pkg::axis_beat_t in_beat [2],
    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready,
    output udp_ip_pkg::ip_hdr_t    out_hdr,
    output logic                   out_beat_valid,
    input  logic                   out_beat_ready,
    output udp_ip_pkg::axis_beat_t out_beat
);

    logic locked;
    logic grant;
    logic sel;
    logic hdr_fire;
    logic last_fire;

    // Lowest index requester wins
    assign sel = !in_hdr_valid[0];

    assign out_hdr_valid = !locked && in_hdr_valid[sel];
    assign out_hdr       = in_hdr[sel];
    assign hdr_fire      = out_hdr_valid && out_hdr_ready;

    assign out_beat_valid = locked && in_beat_valid[grant];
    assign out_beat       = in_beat[grant];
    assign last_fire      = out_beat_valid && out_beat_ready && out_beat.last;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            in_hdr_ready[i]  = hdr_fire && (sel == 1'(i));
            in_beat_ready[i] = locked && (grant == 1'(i)) && out_beat_ready;
        end
    end

    // Grant taken with the header, released after the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            grant  <= 1'b0;
        end else if (hdr_fire) begin
            locked <= 1'b1;
            grant  <= sel;
        end else if (last_fire) begin
            locked <= 1'b0;
        end
    end

endmodule

// ==== design/udp_ip_dispatch.sv ====
// Top level of the UDP/IP dispatch layer between an IPv4 stack and its UDP and raw IP users
`timescale 1ns/1ps

module udp_ip_dispatch (
    input  logic                       clk,
    input  logic                       rst,
    // Receive stream from the IP stack
    input  logic                       s_ip_rx_hdr_valid,
    output logic                       s_ip_rx_hdr_ready,
    input  udp_ip_pkg::ip_hdr_t        s_ip_rx_hdr,
    input  logic                       s_ip_rx_beat_valid,
    output logic                       s_ip_rx_beat_ready,
    input  udp_ip_pkg::axis_beat_t     s_ip_rx_beat,
    // Raw IP receive output
    output logic                       m_ip_hdr_valid,
    input  logic                       m_ip_hdr_ready,
    output udp_ip_pkg::ip_hdr_t        m_ip_hdr,
    output logic                       m_ip_beat_valid,
    input  logic                       m_ip_beat_ready,
    output udp_ip_pkg::axis_beat_t     m_ip_beat,
    // UDP receive output
    output logic                       m_udp_hdr_valid,
    input  logic                       m_udp_hdr_ready,
    output udp_ip_pkg::udp_frame_hdr_t m_udp_hdr,
    output logic                       m_udp_beat_valid,
    input  logic                       m_udp_beat_ready,
    output udp_ip_pkg::axis_beat_t     m_udp_beat,
    // Raw IP transmit input
    input  logic                       s_ip_hdr_valid,
    output logic                       s_ip_hdr_ready,
    input  udp_ip_pkg::ip_hdr_t        s_ip_hdr,
    input  logic                       s_ip_beat_valid,
    output logic                       s_ip_beat_ready,
    input  udp_ip_pkg::axis_beat_t     s_ip_beat,
    // UDP transmit input
    input  logic                       s_udp_hdr_valid,
    output logic                       s_udp_hdr_ready,
    input  udp_ip_pkg::udp_frame_hdr_t s_udp_hdr,
    input  logic                       s_udp_beat_valid,
    output logic                       s_udp_beat_ready,
    input  udp_ip_pkg::axis_beat_t     s_udp_beat,
    // Transmit stream to the IP stack
    output logic                       m_ip_tx_hdr_valid,
    input  logic                       m_ip_tx_hdr_ready,
    output udp_ip_pkg::ip_hdr_t        m_ip_tx_hdr,
    output logic                       m_ip_tx_beat_valid,
    input  logic                       m_ip_tx_beat_ready,
    output udp_ip_pkg::axis_beat_t     m_ip_tx_beat,
    output logic                       udp_rx_error_header_early_termination
);
    import udp_ip_pkg::*;

    logic class_udp_hdr_valid;
    logic class_udp_hdr_ready;
    logic class_udp_beat_valid;
    logic class_udp_beat_ready;

    // Arbiter inputs, 0 is the framed UDP stream and 1 the raw stream
    wire logic       arb_hdr_valid [2];
    wire logic       arb_hdr_ready [2];
    wire ip_hdr_t    arb_hdr [2];
    wire logic       arb_beat_valid [2];
    wire logic       arb_beat_ready [2];
    wire axis_beat_t arb_beat [2];

    // Raw IP receive shares header and beat data with the parser
    assign m_ip_hdr  = s_ip_rx_hdr;
    assign m_ip_beat = s_ip_rx_beat;

    proto_classifier u_classifier (
        .clk            (clk),
        .rst            (rst),
        .in_hdr_valid   (s_ip_rx_hdr_valid),
        .in_hdr_ready   (s_ip_rx_hdr_ready),
        .in_hdr         (s_ip_rx_hdr),
        .in_beat_valid  (s_ip_rx_beat_valid),
        .in_beat_ready  (s_ip_rx_beat_ready),
        .in_beat        (s_ip_rx_beat),
        .udp_hdr_valid  (class_udp_hdr_valid),
        .udp_hdr_ready  (class_udp_hdr_ready),
        .udp_beat_valid (class_udp_beat_valid),
        .udp_beat_ready (class_udp_beat_ready),
        .ip_hdr_valid   (m_ip_hdr_valid),
        .ip_hdr_ready   (m_ip_hdr_ready),
        .ip_beat_valid  (m_ip_beat_valid),
        .ip_beat_ready  (m_ip_beat_ready)
    );

    udp_rx_parse u_rx_parse (
        .clk                            (clk),
        .rst                            (rst),
        .in_hdr_valid                   (class_udp_hdr_valid),
        .in_hdr_ready                   (class_udp_hdr_ready),
        .in_hdr                         (s_ip_rx_hdr),
        .in_beat_valid                  (class_udp_beat_valid),
        .in_beat_ready                  (class_udp_beat_ready),
        .in_beat                        (s_ip_rx_beat),
        .out_hdr_valid                  (m_udp_hdr_valid),
        .out_hdr_ready                  (m_udp_hdr_ready),
        .out_hdr                        (m_udp_hdr),
        .out_beat_valid                 (m_udp_beat_valid),
        .out_beat_ready                 (m_udp_beat_ready),
        .out_beat                       (m_udp_beat),
        .error_header_early_termination (udp_rx_error_header_early_termination)
    );

    udp_tx_frame u_tx_frame (
        .clk            (clk),
        .rst            (rst),
        .in_hdr_valid   (s_udp_hdr_valid),
        .in_hdr_ready   (s_udp_hdr_ready),
        .in_hdr         (s_udp_hdr),
        .in_beat_valid  (s_udp_beat_valid),
        .in_beat_ready  (s_udp_beat_ready),
        .in_beat        (s_udp_beat),
        .out_hdr_valid  (arb_hdr_valid[0]),
        .out_hdr_ready  (arb_hdr_ready[0]),
        .out_hdr        (arb_hdr[0]),
        .out_beat_valid (arb_beat_valid[0]),
        .out_beat_ready (arb_beat_ready[0]),
        .out_beat       (arb_beat[0])
    );

    assign arb_hdr_valid[1]  = s_ip_hdr_valid;
    assign arb_hdr[1]        = s_ip_hdr;
    assign arb_beat_valid[1] = s_ip_beat_valid;
    assign arb_beat[1]       = s_ip_beat;
    assign s_ip_hdr_ready    = arb_hdr_ready[1];
    assign s_ip_beat_ready   = arb_beat_ready[1];

    tx_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .in_hdr_valid   (arb_hdr_valid),
        .in_hdr_ready   (arb_hdr_ready),
        .in_hdr         (arb_hdr),
        .in_beat_valid  (arb_beat_valid),
        .in_beat_ready  (arb_beat_ready),
        .in_beat        (arb_beat),
        .out_hdr_valid  (m_ip_tx_hdr_valid),
        .out_hdr_ready  (m_ip_tx_hdr_ready),
        .out_hdr        (m_ip_tx_hdr),
        .out_beat_valid (m_ip_tx_beat_valid),
        .out_beat_ready (m_ip_tx_beat_ready),
        .out_beat       (m_ip_tx_beat)
    );

endmodule

// ==== tests/tb_udp_ip_dispatch.sv ====
// Self-checking testbench for udp_ip_dispatch, drives receive and transmit frames and checks outputs
`timescale 1ns/1ps

module tb_udp_ip_dispatch;
    import udp_ip_pkg::*;

    // Total beats of all tests times a generous back-pressure allowance
    localparam int TIMEOUT_CYCLES = 4000;

    logic clk;
    logic rst;
    logic s_ip_rx_hdr_valid, s_ip_rx_hdr_ready, s_ip_rx_beat_valid, s_ip_rx_beat_ready;
    logic m_ip_hdr_valid, m_ip_hdr_ready, m_ip_beat_valid, m_ip_beat_ready;
    logic m_udp_hdr_valid, m_udp_hdr_ready, m_udp_beat_valid, m_udp_beat_ready;
    logic s_ip_hdr_valid, s_ip_hdr_ready, s_ip_beat_valid, s_ip_beat_ready;
    logic s_udp_hdr_valid, s_udp_hdr_ready, s_udp_beat_valid, s_udp_beat_ready;
    logic m_ip_tx_hdr_valid, m_ip_tx_hdr_ready, m_ip_tx_beat_valid, m_ip_tx_beat_ready;
    logic udp_rx_error_header_early_termination;
    ip_hdr_t s_ip_rx_hdr, m_ip_hdr, s_ip_hdr, m_ip_tx_hdr;
    udp_frame_hdr_t m_udp_hdr, s_udp_hdr;
    axis_beat_t s_ip_rx_beat, m_ip_beat, m_udp_beat, s_ip_beat, s_udp_beat, m_ip_tx_beat;

    logic back_pressure;
    logic hold_tx_hdr;
    int cycles;
    int checks;
    int errors;
    int exp_err_pulses;
    int err_pulses;

    // Source beats per input and expected outputs per output
    axis_beat_t rx_src[$], udp_src[$], raw_src[$];
    ip_hdr_t exp_ip_hdr[$], exp_tx_hdr[$];
    udp_frame_hdr_t exp_udp_hdr[$];
    axis_beat_t exp_ip_beat[$], exp_udp_beat[$], exp_tx_beat[$];

    udp_ip_dispatch UUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Output readies, random under back-pressure
    always @(posedge clk) begin
        #1;
        m_ip_hdr_ready     = !back_pressure || ($urandom % 4 != 0);
        m_ip_beat_ready    = !back_pressure || ($urandom % 4 != 0);
        m_udp_hdr_ready    = !back_pressure || ($urandom % 4 != 0);
        m_udp_beat_ready   = !back_pressure || ($urandom % 4 != 0);
        m_ip_tx_hdr_ready  = !hold_tx_hdr && (!back_pressure || ($urandom % 4 != 0));
        m_ip_tx_beat_ready = !back_pressure || ($urandom % 4 != 0);
    end

    task automatic check_value(input string name, input logic [167:0] expected,
                               input logic [167:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic check_queued(input string what, input int depth);
        checks++;
        assert (depth != 0) else begin
            errors++;
            $display("Unexpected %s transfer while no output was expected", what);
        end
    endtask

    // Transfers are sampled mid-cycle, where all handshake signals are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (m_ip_hdr_valid && m_ip_hdr_ready) begin
                check_queued("m_ip header", exp_ip_hdr.size());
                if (exp_ip_hdr.size() != 0)
                    check_value("m_ip_hdr", exp_ip_hdr.pop_front(), m_ip_hdr);
            end
            if (m_ip_beat_valid && m_ip_beat_ready) begin
                check_queued("m_ip beat", exp_ip_beat.size());
                if (exp_ip_beat.size() != 0)
                    check_value("m_ip_beat", exp_ip_beat.pop_front(), m_ip_beat);
            end
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                check_queued("m_udp header", exp_udp_hdr.size());
                if (exp_udp_hdr.size() != 0)
                    check_value("m_udp_hdr", exp_udp_hdr.pop_front(), m_udp_hdr);
            end
            if (m_udp_beat_valid && m_udp_beat_ready) begin
                check_queued("m_udp beat", exp_udp_beat.size());
                if (exp_udp_beat.size() != 0)
                    check_value("m_udp_beat", exp_udp_beat.pop_front(), m_udp_beat);
            end
            if (m_ip_tx_hdr_valid && m_ip_tx_hdr_ready) begin
                check_queued("m_ip_tx header", exp_tx_hdr.size());
                if (exp_tx_hdr.size() != 0)
                    check_value("m_ip_tx_hdr", exp_tx_hdr.pop_front(), m_ip_tx_hdr);
            end
            if (m_ip_tx_beat_valid && m_ip_tx_beat_ready) begin
                check_queued("m_ip_tx beat", exp_tx_beat.size());
                if (exp_tx_beat.size() != 0)
                    check_value("m_ip_tx_beat", exp_tx_beat.pop_front(), m_ip_tx_beat);
            end
            if (udp_rx_error_header_early_termination)
                err_pulses++;
        end
    end

    function automatic ip_hdr_t random_ip_hdr(input logic [7:0] proto);
        ip_hdr_t h;
        h = {$urandom, $urandom, $urandom, $urandom};
        h.protocol = proto;
        return h;
    endfunction

    function automatic axis_beat_t random_beat(input logic last);
        axis_beat_t b;
        b.data = {$urandom, $urandom};
        b.keep = last ? (8'hff >> ($urandom % 8)) : 8'hff;
        b.last = last;
        b.user = $urandom % 2;
        return b;
    endfunction

    // UDP header fields in wire order, byte 0 is the high byte of source port
    function automatic udp_hdr_t udp_fields_of(input axis_beat_t b);
        logic [63:0] msb_first;
        for (int i = 0; i < 8; i++)
            msb_first[63-8*i -: 8] = b.data[8*i +: 8];
        return msb_first;
    endfunction

    function automatic axis_beat_t udp_header_beat(input udp_hdr_t h);
        axis_beat_t b;
        logic [63:0] msb_first;
        msb_first = {h.source_port, h.dest_port, h.length, h.checksum};
        for (int i = 0; i < 8; i++)
            b.data[8*i +: 8] = msb_first[63-8*i -: 8];
        b.keep = 8'hff;
        b.last = 1'b0;
        b.user = 1'b0;
        return b;
    endfunction

    // A 20-byte IPv4 header carrying protocol 17
    function automatic ip_hdr_t framed_ip_hdr(input udp_frame_hdr_t req);
        ip_hdr_t h;
        h = req.ip;
        h.length = req.udp.length + 16'd20;
        h.protocol = 8'd17;
        return h;
    endfunction

    task automatic send_rx_frame(input ip_hdr_t hdr);
        axis_beat_t b;
        s_ip_rx_hdr = hdr;
        s_ip_rx_hdr_valid = 1'b1;
        do @(negedge clk); while (!s_ip_rx_hdr_ready);
        @(posedge clk);
        #1;
        s_ip_rx_hdr_valid = 1'b0;
        do begin
            b = rx_src.pop_front();
            s_ip_rx_beat = b;
            s_ip_rx_beat_valid = 1'b1;
            do @(negedge clk); while (!s_ip_rx_beat_ready);
            @(posedge clk);
            #1;
        end while (!b.last);
        s_ip_rx_beat_valid = 1'b0;
    endtask

    task automatic send_udp_req(input udp_frame_hdr_t hdr);
        axis_beat_t b;
        s_udp_hdr = hdr;
        s_udp_hdr_valid = 1'b1;
        do @(negedge clk); while (!s_udp_hdr_ready);
        @(posedge clk);
        #1;
        s_udp_hdr_valid = 1'b0;
        do begin
            b = udp_src.pop_front();
            s_udp_beat = b;
            s_udp_beat_valid = 1'b1;
            do @(negedge clk); while (!s_udp_beat_ready);
            @(posedge clk);
            #1;
        end while (!b.last);
        s_udp_beat_valid = 1'b0;
    endtask

    task automatic send_raw_tx(input ip_hdr_t hdr);
        axis_beat_t b;
        s_ip_hdr = hdr;
        s_ip_hdr_valid = 1'b1;
        do @(negedge clk); while (!s_ip_hdr_ready);
        @(posedge clk);
        #1;
        s_ip_hdr_valid = 1'b0;
        do begin
            b = raw_src.pop_front();
            s_ip_beat = b;
            s_ip_beat_valid = 1'b1;
            do @(negedge clk); while (!s_ip_beat_ready);
            @(posedge clk);
            #1;
        end while (!b.last);
        s_ip_beat_valid = 1'b0;
    endtask

    // Queue a UDP request and the IP frame it should become
    task automatic prepare_udp_req(input udp_frame_hdr_t req, input int beats);
        axis_beat_t b;
        exp_tx_hdr.push_back(framed_ip_hdr(req));
        exp_tx_beat.push_back(udp_header_beat(req.udp));
        for (int i = 0; i < beats; i++) begin
            b = random_beat(i == beats - 1);
            udp_src.push_back(b);
            exp_tx_beat.push_back(b);
        end
    endtask

    task automatic prepare_raw_tx(input ip_hdr_t hdr, input int beats);
        axis_beat_t b;
        exp_tx_hdr.push_back(hdr);
        for (int i = 0; i < beats; i++) begin
            b = random_beat(i == beats - 1);
            raw_src.push_back(b);
            exp_tx_beat.push_back(b);
        end
    endtask

    task automatic wait_outputs_done();
        while (exp_ip_hdr.size() + exp_ip_beat.size() + exp_udp_hdr.size()
               + exp_udp_beat.size() + exp_tx_hdr.size() + exp_tx_beat.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        #1;
    endtask

    initial begin
        ip_hdr_t ih;
        udp_frame_hdr_t uh;
        axis_beat_t b;
        void'($urandom(40));
        clk = 1'b0;
        rst = 1'b1;
        back_pressure = 1'b0;
        hold_tx_hdr = 1'b0;
        {s_ip_rx_hdr_valid, s_ip_rx_beat_valid, s_ip_hdr_valid, s_ip_beat_valid} = '0;
        {s_udp_hdr_valid, s_udp_beat_valid} = '0;
        {m_ip_hdr_ready, m_ip_beat_ready, m_udp_hdr_ready, m_udp_beat_ready} = '1;
        {m_ip_tx_hdr_ready, m_ip_tx_beat_ready} = '1;
        s_ip_rx_hdr = '0;
        s_ip_hdr = '0;
        s_udp_hdr = '0;
        {s_ip_rx_beat, s_ip_beat, s_udp_beat} = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle outputs after reset
        @(negedge clk);
        check_value("m_ip_hdr_valid", 0, m_ip_hdr_valid);
        check_value("m_ip_beat_valid", 0, m_ip_beat_valid);
        check_value("m_udp_hdr_valid", 0, m_udp_hdr_valid);
        check_value("m_udp_beat_valid", 0, m_udp_beat_valid);
        check_value("m_ip_tx_hdr_valid", 0, m_ip_tx_hdr_valid);
        check_value("m_ip_tx_beat_valid", 0, m_ip_tx_beat_valid);
        check_value("s_ip_rx_hdr_ready", 0, s_ip_rx_hdr_ready);
        check_value("s_ip_hdr_ready", 0, s_ip_hdr_ready);
        check_value("s_udp_hdr_ready", 0, s_udp_hdr_ready);
        check_value("udp_rx_error_header_early_termination", 0,
                    udp_rx_error_header_early_termination);
        back_pressure = 1'b1;
        @(posedge clk);
        #1;

        // TCP frame passes unchanged on the raw port
        ih = random_ip_hdr(8'd6);
        exp_ip_hdr.push_back(ih);
        for (int i = 0; i < 3; i++) begin
            b = random_beat(i == 2);
            rx_src.push_back(b);
            exp_ip_beat.push_back(b);
        end
        send_rx_frame(ih);
        wait_outputs_done();

        // UDP frame loses its header beat
        ih = random_ip_hdr(8'd17);
        b = random_beat(1'b0);
        rx_src.push_back(b);
        uh.ip = ih;
        uh.udp = udp_fields_of(b);
        exp_udp_hdr.push_back(uh);
        for (int i = 0; i < 3; i++) begin
            b = random_beat(i == 2);
            rx_src.push_back(b);
            exp_udp_beat.push_back(b);
        end
        send_rx_frame(ih);
        wait_outputs_done();

        // UDP frame that ends inside its header beat
        ih = random_ip_hdr(8'd17);
        rx_src.push_back(random_beat(1'b1));
        exp_err_pulses++;
        send_rx_frame(ih);
        wait_outputs_done();

        // UDP transmit request
        uh.ip = random_ip_hdr($urandom);
        uh.udp = {$urandom, $urandom};
        prepare_udp_req(uh, 2);
        send_udp_req(uh);
        wait_outputs_done();

        // UDP and raw requests together, sink stalled while both arrive
        uh.ip = random_ip_hdr($urandom);
        uh.udp = {$urandom, $urandom};
        ih = random_ip_hdr(8'd6);
        prepare_udp_req(uh, 3);
        prepare_raw_tx(ih, 2);
        hold_tx_hdr = 1'b1;
        @(posedge clk);
        #1;
        fork
            send_udp_req(uh);
            send_raw_tx(ih);
            begin
                repeat (3) @(posedge clk);
                hold_tx_hdr = 1'b0;
            end
        join
        wait_outputs_done();

        check_value("udp_rx_error_header_early_termination pulses", exp_err_pulses, err_pulses);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+design
design/udp_ip_pkg.sv
design/proto_classifier.sv
design/udp_rx_parse.sv
design/udp_tx_frame.sv
design/tx_arbiter.sv
design/udp_ip_dispatch.sv
tests/tb_udp_ip_dispatch.sv
